/* syscon_pkg.sv */
package syscon_pkg;

    typedef logic [7:0]  reg_addr_t;   // Register word address
    typedef logic [31:0] reg_word_t;   // Register data word
    typedef logic [7:0]  uart_byte_t;  // One UART character

    // Register map
    localparam reg_addr_t ADDR_SCRATCH0  = 8'h00;  // Scratch pad 0, read/write
    localparam reg_addr_t ADDR_SCRATCH1  = 8'h01;  // Scratch pad 1, read/write
    localparam reg_addr_t ADDR_ID        = 8'h02;  // ID word, read only
    localparam reg_addr_t ADDR_CLK_CTRL  = 8'h10;  // Bit 0 enables pulse chain
    localparam reg_addr_t ADDR_OSC_COUNT = 8'h20;  // Read result, write restarts

    localparam reg_word_t SYSCON_ID = 32'h5359_5301;  // "SYS" plus revision

    // Host command opcodes, ASCII 'W' and 'R'
    typedef enum logic [7:0] {
        OP_WRITE = 8'h57,
        OP_READ  = 8'h52
    } cmd_op_e;

    localparam uart_byte_t REPLY_ACK = 8'h06;  // Write done
    localparam uart_byte_t REPLY_NAK = 8'h15;  // Unknown opcode

    localparam logic [7:0] PULSE_RATIO = 8'd10;  // Division between pulse stages

    // Command parser states
    typedef enum logic [2:0] {
        CMD_IDLE,   // Waiting for opcode
        CMD_ADDR,   // Waiting for address byte
        CMD_DATA,   // Collecting four write bytes
        CMD_EXEC,   // Bus strobe cycle
        CMD_REPLY   // Read data capture
    } cmd_state_e;

endpackage

/* uart_port.sv */
module uart_port import syscon_pkg::*; #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic       sys_clk,
    input  logic       rst,
    input  logic       rxd,
    input  logic       tx_start,
    input  uart_byte_t tx_byte,
    output logic       txd,
    output logic       rx_valid,
    output uart_byte_t rx_byte,
    output logic       tx_busy
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_MAX  = CNT_W'(CLKS_PER_BIT - 1);      // Full bit time
    localparam logic [CNT_W-1:0] HALF_MAX = CNT_W'(CLKS_PER_BIT / 2 - 1);  // To mid start bit

    logic             rxd_meta;
    logic             rxd_sync;
    logic             rx_active;   // Frame in progress
    logic [CNT_W-1:0] rx_cnt;      // Down counter to next sample point
    logic [3:0]       rx_bit;      // 0 start, 1..8 data, 9 stop
    uart_byte_t       rx_shift;
    logic [CNT_W-1:0] tx_cnt;
    logic [3:0]       tx_bit;
    logic [9:0]       tx_shift;    // Stop, data, start

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;      // Line idles high
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            rx_active <= 1'b0;
            rx_cnt    <= '0;
            rx_bit    <= '0;
            rx_shift  <= '0;
            rx_byte   <= '0;
            rx_valid  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!rx_active) begin
                if (!rxd_sync) begin       // Falling edge of start bit
                    rx_active <= 1'b1;
                    rx_cnt    <= HALF_MAX;
                    rx_bit    <= '0;
                end
            end else if (rx_cnt != '0) begin
                rx_cnt <= rx_cnt - 1'b1;
            end else begin
                rx_cnt <= BIT_MAX;
                rx_bit <= rx_bit + 4'd1;
                if (rx_bit == 4'd0) begin
                    if (rxd_sync) begin
                        rx_active <= 1'b0; // Glitch, not a start bit
                    end
                end else if (rx_bit == 4'd9) begin
                    rx_active <= 1'b0;
                    if (rxd_sync) begin    // Good stop bit only
                        rx_valid <= 1'b1;
                        rx_byte  <= rx_shift;
                    end
                end else begin
                    rx_shift <= {rxd_sync, rx_shift[7:1]};  // LSB first
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            tx_busy  <= 1'b0;
            tx_cnt   <= '0;
            tx_bit   <= '0;
            tx_shift <= '1;        // txd high out of reset
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy  <= 1'b1;
                tx_shift <= {1'b1, tx_byte, 1'b0};
                tx_cnt   <= BIT_MAX;
                tx_bit   <= '0;
            end
        end else if (tx_cnt != '0) begin
            tx_cnt <= tx_cnt - 1'b1;
        end else begin
            tx_cnt   <= BIT_MAX;
            tx_shift <= {1'b1, tx_shift[9:1]};
            tx_bit   <= tx_bit + 4'd1;
            if (tx_bit == 4'd9) begin
                tx_busy <= 1'b0;   // Stop bit fully sent
            end
        end
    end

    assign txd = tx_shift[0];

    // Server must wait for the previous frame to finish
    a_no_start_busy: assert property (@(posedge sys_clk) disable iff (rst)
        !(tx_start && tx_busy));

endmodule

/* cmd_server.sv */
module cmd_server import syscon_pkg::*; (
    input  logic       sys_clk,
    input  logic       rst,
    input  logic       rx_valid,
    input  uart_byte_t rx_byte,
    input  logic       tx_busy,
    input  reg_word_t  bus_rdata,
    output logic       tx_start,
    output uart_byte_t tx_byte,
    output reg_addr_t  bus_addr,
    output reg_word_t  bus_wdata,
    output logic       bus_re,
    output logic       bus_we
);

    cmd_state_e state;
    cmd_op_e    op;           // Opcode of current frame
    logic [1:0] byte_cnt;     // Write data bytes received
    reg_word_t  reply_shift;  // Reply bytes, next one in the top byte
    logic [2:0] reply_cnt;    // Reply bytes still to send

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            state       <= CMD_IDLE;
            op          <= OP_READ;
            byte_cnt    <= '0;
            bus_addr    <= '0;
            bus_wdata   <= '0;
            reply_shift <= '0;
            reply_cnt   <= '0;
            tx_start    <= 1'b0;
            tx_byte     <= '0;
        end else begin
            tx_start <= 1'b0;

            // Reply sender hands over one byte whenever the transmitter is free
            if (reply_cnt != 3'd0 && !tx_busy && !tx_start) begin
                tx_start    <= 1'b1;
                tx_byte     <= reply_shift[31:24];
                reply_shift <= reply_shift << 8;
                reply_cnt   <= reply_cnt - 3'd1;
            end

            // A new reply load in the parser overrides the sender
            case (state)
                CMD_IDLE: begin
                    if (rx_valid) begin
                        if (rx_byte == OP_WRITE || rx_byte == OP_READ) begin
                            op    <= cmd_op_e'(rx_byte);
                            state <= CMD_ADDR;
                        end else begin
                            reply_shift <= {REPLY_NAK, 24'h0};  // Stay idle
                            reply_cnt   <= 3'd1;
                        end
                    end
                end
                CMD_ADDR: begin
                    if (rx_valid) begin
                        bus_addr <= rx_byte;
                        byte_cnt <= '0;
                        state    <= (op == OP_WRITE) ? CMD_DATA : CMD_EXEC;
                    end
                end
                CMD_DATA: begin
                    if (rx_valid) begin
                        bus_wdata <= {bus_wdata[23:0], rx_byte};  // MSB first
                        byte_cnt  <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3) begin
                            state <= CMD_EXEC;
                        end
                    end
                end
                CMD_EXEC: begin
                    if (op == OP_WRITE) begin
                        reply_shift <= {REPLY_ACK, 24'h0};
                        reply_cnt   <= 3'd1;
                        state       <= CMD_IDLE;
                    end else begin
                        state <= CMD_REPLY;  // Read data arrives next cycle
                    end
                end
                CMD_REPLY: begin
                    reply_shift <= bus_rdata;
                    reply_cnt   <= 3'd4;
                    state       <= CMD_IDLE;
                end
                default: state <= CMD_IDLE;
            endcase
        end
    end

    // Single strobe cycle right after the last command byte
    assign bus_re = (state == CMD_EXEC) && (op == OP_READ);
    assign bus_we = (state == CMD_EXEC) && (op == OP_WRITE);

    // Bus cycle only ever follows a received byte
    a_strobe_after_byte: assert property (@(posedge sys_clk) disable iff (rst)
        (bus_re || bus_we) |-> $past(rx_valid));

endmodule

/* reg_decode.sv */
module reg_decode import syscon_pkg::*; (
    input  logic      sys_clk,
    input  logic      rst,
    input  reg_addr_t bus_addr,
    input  reg_word_t bus_wdata,
    input  logic      bus_re,
    input  logic      bus_we,
    input  reg_word_t clk_ctrl,
    input  reg_word_t osc_count,
    output reg_word_t bus_rdata,
    output logic      clk_ctrl_we,
    output logic      osc_we
);

    reg_word_t scratch0;
    reg_word_t scratch1;

    // Block write strobes, same cycle as bus_we
    assign clk_ctrl_we = bus_we && (bus_addr == ADDR_CLK_CTRL);
    assign osc_we      = bus_we && (bus_addr == ADDR_OSC_COUNT);

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            scratch0 <= '0;
            scratch1 <= '0;
        end else if (bus_we) begin
            if (bus_addr == ADDR_SCRATCH0) scratch0 <= bus_wdata;
            if (bus_addr == ADDR_SCRATCH1) scratch1 <= bus_wdata;
        end
    end

    // Registered read mux, data valid the cycle after bus_re
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            bus_rdata <= '0;
        end else if (bus_re) begin
            case (bus_addr)
                ADDR_SCRATCH0:  bus_rdata <= scratch0;
                ADDR_SCRATCH1:  bus_rdata <= scratch1;
                ADDR_ID:        bus_rdata <= SYSCON_ID;
                ADDR_CLK_CTRL:  bus_rdata <= clk_ctrl;
                ADDR_OSC_COUNT: bus_rdata <= osc_count;
                default:        bus_rdata <= '0;  // Unmapped
            endcase
        end
    end

endmodule

/* pulse_gen.sv */
module pulse_gen import syscon_pkg::*; #(
    parameter int CLKS_PER_TICK = 250,
    parameter int SLOW_DIV      = 1000
) (
    input  logic      sys_clk,
    input  logic      rst,
    input  logic      clk_ctrl_we,
    input  reg_word_t bus_wdata,
    output reg_word_t clk_ctrl,
    output logic      pulse_200k,
    output logic      pulse_20k,
    output logic      pulse_2k,
    output logic      power_good
);

    localparam int TICK_W = $clog2(CLKS_PER_TICK + 1);
    localparam int SLOW_W = $clog2(SLOW_DIV + 1);
    localparam logic [TICK_W-1:0] TICK_MAX = TICK_W'(CLKS_PER_TICK - 1);
    localparam logic [SLOW_W-1:0] SLOW_MAX = SLOW_W'(SLOW_DIV - 1);
    localparam logic [7:0]        DEC_MAX  = PULSE_RATIO - 8'd1;

    logic              enable;
    logic [TICK_W-1:0] tick_cnt;   // System clocks within one 200 kHz period
    logic [7:0]        dec1_cnt;   // 200 kHz pulses within 20 kHz period
    logic [7:0]        dec2_cnt;   // 20 kHz pulses within 2 kHz period
    logic [SLOW_W-1:0] slow_cnt;   // 2 kHz pulses per power_good half period
    logic              hit_200k;
    logic              hit_20k;
    logic              hit_2k;

    assign enable   = clk_ctrl[0];
    assign hit_200k = enable && (tick_cnt == TICK_MAX);
    assign hit_20k  = hit_200k && (dec1_cnt == DEC_MAX);  // Nested so stages coincide
    assign hit_2k   = hit_20k && (dec2_cnt == DEC_MAX);

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            clk_ctrl <= '0;
        end else if (clk_ctrl_we) begin
            clk_ctrl <= {31'h0, bus_wdata[0]};
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            tick_cnt   <= '0;
            dec1_cnt   <= '0;
            dec2_cnt   <= '0;
            slow_cnt   <= '0;
            pulse_200k <= 1'b0;
            pulse_20k  <= 1'b0;
            pulse_2k   <= 1'b0;
            power_good <= 1'b0;
        end else if (clk_ctrl_we) begin
            tick_cnt   <= '0;          // Restart whole chain
            dec1_cnt   <= '0;
            dec2_cnt   <= '0;
            slow_cnt   <= '0;
            pulse_200k <= 1'b0;
            pulse_20k  <= 1'b0;
            pulse_2k   <= 1'b0;
        end else begin
            pulse_200k <= hit_200k;
            pulse_20k  <= hit_20k;
            pulse_2k   <= hit_2k;
            if (enable) begin
                tick_cnt <= hit_200k ? '0 : tick_cnt + 1'b1;
            end
            if (hit_200k) begin
                dec1_cnt <= hit_20k ? 8'd0 : dec1_cnt + 8'd1;
            end
            if (hit_20k) begin
                dec2_cnt <= hit_2k ? 8'd0 : dec2_cnt + 8'd1;
            end
            if (hit_2k) begin
                if (slow_cnt == SLOW_MAX) begin
                    slow_cnt   <= '0;
                    power_good <= ~power_good;  // Slow square wave
                end else begin
                    slow_cnt <= slow_cnt + 1'b1;
                end
            end
        end
    end

    // Every divider wraps at its terminal count
    a_cnt_range: assert property (@(posedge sys_clk) disable iff (rst)
        tick_cnt <= TICK_MAX && dec1_cnt <= DEC_MAX &&
        dec2_cnt <= DEC_MAX && slow_cnt <= SLOW_MAX);

endmodule

/* osc_counter.sv */
module osc_counter import syscon_pkg::*; #(
    parameter int GATE_CLKS = 50000
) (
    input  logic      sys_clk,
    input  logic      rst,
    input  logic      ref_clk,
    input  logic      osc_we,
    output reg_word_t osc_count
);

    localparam int GATE_W = $clog2(GATE_CLKS + 1);
    localparam logic [GATE_W-1:0] GATE_MAX = GATE_W'(GATE_CLKS - 1);

    logic              ref_meta;
    logic              ref_sync;
    logic              ref_prev;     // For edge detect
    logic              ref_rise;
    logic              gate_active;  // Measurement window open
    logic [GATE_W-1:0] gate_cnt;
    reg_word_t         edge_cnt;

    assign ref_rise = ref_sync && !ref_prev;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            ref_meta <= 1'b0;
            ref_sync <= 1'b0;
            ref_prev <= 1'b0;
        end else begin
            ref_meta <= ref_clk;   // Async reference, two flops
            ref_sync <= ref_meta;
            ref_prev <= ref_sync;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            gate_active <= 1'b0;
            gate_cnt    <= '0;
            edge_cnt    <= '0;
            osc_count   <= '0;
        end else if (osc_we) begin
            gate_active <= 1'b1;   // Window opens next cycle
            gate_cnt    <= '0;
            edge_cnt    <= '0;
        end else if (gate_active) begin
            gate_cnt <= gate_cnt + 1'b1;
            edge_cnt <= edge_cnt + (ref_rise ? 32'd1 : 32'd0);
            if (gate_cnt == GATE_MAX) begin
                gate_active <= 1'b0;
                osc_count   <= edge_cnt + (ref_rise ? 32'd1 : 32'd0);  // Include last cycle
            end
        end
    end

endmodule

/* syscon_top.sv */
module syscon_top import syscon_pkg::*; #(
    parameter int CLKS_PER_BIT  = 434,    // 115200 baud at 50 MHz
    parameter int CLKS_PER_TICK = 250,    // 200 kHz at 50 MHz
    parameter int SLOW_DIV      = 1000,   // 1 Hz power_good
    parameter int GATE_CLKS     = 50000   // 1 ms window
) (
    input  logic sys_clk,
    input  logic rst,
    input  logic uart_rxd,
    input  logic ref_clk_16khz,
    output logic uart_txd,
    output logic pulse_20khz,
    output logic pulse_2khz,
    output logic power_good
);

    logic       rx_valid;
    uart_byte_t rx_byte;
    logic       tx_start;
    uart_byte_t tx_byte;
    logic       tx_busy;
    reg_addr_t  bus_addr;
    reg_word_t  bus_wdata;
    reg_word_t  bus_rdata;
    logic       bus_re;
    logic       bus_we;
    logic       clk_ctrl_we;
    logic       osc_we;
    reg_word_t  clk_ctrl;
    reg_word_t  osc_count;

    uart_port #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_port_i (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .rxd      (uart_rxd),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .txd      (uart_txd),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .tx_busy  (tx_busy)
    );

    cmd_server cmd_server_i (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .rx_valid  (rx_valid),
        .rx_byte   (rx_byte),
        .tx_busy   (tx_busy),
        .bus_rdata (bus_rdata),
        .tx_start  (tx_start),
        .tx_byte   (tx_byte),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_re    (bus_re),
        .bus_we    (bus_we)
    );

    reg_decode reg_decode_i (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_re      (bus_re),
        .bus_we      (bus_we),
        .clk_ctrl    (clk_ctrl),
        .osc_count   (osc_count),
        .bus_rdata   (bus_rdata),
        .clk_ctrl_we (clk_ctrl_we),
        .osc_we      (osc_we)
    );

    pulse_gen #(
        .CLKS_PER_TICK (CLKS_PER_TICK),
        .SLOW_DIV      (SLOW_DIV)
    ) pulse_gen_i (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .clk_ctrl_we (clk_ctrl_we),
        .bus_wdata   (bus_wdata),
        .clk_ctrl    (clk_ctrl),
        .pulse_200k  (),             // No consumer left on chip
        .pulse_20k   (pulse_20khz),
        .pulse_2k    (pulse_2khz),
        .power_good  (power_good)
    );

    osc_counter #(.GATE_CLKS(GATE_CLKS)) osc_counter_i (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .ref_clk   (ref_clk_16khz),
        .osc_we    (osc_we),
        .osc_count (osc_count)
    );

endmodule

/* tb_syscon.sv */
module tb_syscon import syscon_pkg::*; ();

    localparam int BIT_CLKS   = 8;      // UART bit time in clocks
    localparam int TICK_CLKS  = 4;      // Clocks per 200 kHz pulse
    localparam int SLOW       = 3;      // 2 kHz pulses per power_good half period
    localparam int GATE       = 400;    // Osc window
    localparam int REF_PERIOD = 20;     // Reference clock period in clocks
    localparam int GAP_20K    = int'(PULSE_RATIO) * TICK_CLKS;
    localparam int GAP_2K     = int'(PULSE_RATIO) * GAP_20K;
    localparam int GAP_PG     = SLOW * GAP_2K;
    localparam int RX_WAIT    = 40 * BIT_CLKS;  // Wait limit for a reply start bit
    localparam int N_CMDS     = 60;             // Upper bound on frames in the run
    localparam int CMD_CYCLES = 10 * 10 * BIT_CLKS + 40;  // Ten bytes plus turnaround
    localparam int LIMIT      = N_CMDS * CMD_CYCLES + 500 + 4 * GAP_PG + 2 * GATE + 1000;

    logic sys_clk;
    logic rst;
    logic uart_rxd;
    logic ref_clk_16khz;
    logic uart_txd;
    logic pulse_20khz;
    logic pulse_2khz;
    logic power_good;

    int          cycle_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          ref_div = 0;
    logic        ref_en;
    logic [31:0] rng_state = 32'd65;   // Fixed seed
    reg_word_t   model_regs [256];     // Expected register contents

    syscon_top #(
        .CLKS_PER_BIT  (BIT_CLKS),
        .CLKS_PER_TICK (TICK_CLKS),
        .SLOW_DIV      (SLOW),
        .GATE_CLKS     (GATE)
    ) dut_i (
        .sys_clk       (sys_clk),
        .rst           (rst),
        .uart_rxd      (uart_rxd),
        .ref_clk_16khz (ref_clk_16khz),
        .uart_txd      (uart_txd),
        .pulse_20khz   (pulse_20khz),
        .pulse_2khz    (pulse_2khz),
        .power_good    (power_good)
    );

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycle_cnt++;
        if (cycle_cnt > LIMIT) begin
            $display("timeout after %0d cycles, a test did not finish", LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    // 16 kHz reference stand-in toggling every half period
    always @(negedge sys_clk) begin
        if (ref_en) begin
            if (ref_div == REF_PERIOD / 2 - 1) begin
                ref_div = 0;
                ref_clk_16khz = ~ref_clk_16khz;
            end else begin
                ref_div++;
            end
        end
    end

    function logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function logic is_mapped(reg_addr_t a);
        return a == ADDR_SCRATCH0 || a == ADDR_SCRATCH1 || a == ADDR_ID ||
               a == ADDR_CLK_CTRL || a == ADDR_OSC_COUNT;
    endfunction

    function void model_write(reg_addr_t a, reg_word_t d);
        if (a == ADDR_SCRATCH0 || a == ADDR_SCRATCH1) model_regs[a] = d;
        if (a == ADDR_CLK_CTRL) model_regs[a] = {31'h0, d[0]};  // Enable bit only
    endfunction

    function reg_word_t model_read(reg_addr_t a);
        if (a == ADDR_ID) return SYSCON_ID;
        return model_regs[a];               // Unmapped stay zero
    endfunction

    task automatic check_word(input string name, input reg_word_t got, input reg_word_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp, input int tol);
        if (got < exp - tol || got > exp + tol) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int fails_at_start);
        $display("%-10s %s", name, (fail_cnt == fails_at_start) ? "passed" : "failed");
    endtask

    task automatic send_byte(input uart_byte_t b);
        uart_rxd = 1'b0;                    // Start bit
        repeat (BIT_CLKS) @(negedge sys_clk);
        for (int i = 0; i < 8; i++) begin
            uart_rxd = b[i];                // LSB first
            repeat (BIT_CLKS) @(negedge sys_clk);
        end
        uart_rxd = 1'b1;                    // Stop bit
        repeat (BIT_CLKS) @(negedge sys_clk);
    endtask

    task automatic recv_byte(output uart_byte_t b);
        int waited;
        waited = 0;
        b = '0;
        while (uart_txd !== 1'b0 && waited < RX_WAIT) begin
            @(negedge sys_clk);
            waited++;
        end
        if (uart_txd !== 1'b0) begin
            $display("no reply byte received within %0d cycles", RX_WAIT);
            fail_cnt++;
        end else begin
            repeat (BIT_CLKS / 2) @(negedge sys_clk);  // Mid start bit
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge sys_clk);
                b[i] = uart_txd;
            end
            repeat (BIT_CLKS) @(negedge sys_clk);
            if (uart_txd !== 1'b1) begin
                $display("reply byte had a low stop bit");
                fail_cnt++;
            end
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_word_t data);
        uart_byte_t reply;
        send_byte(OP_WRITE);
        send_byte(addr);
        for (int i = 3; i >= 0; i--) send_byte(data[i*8 +: 8]);  // MSB first
        recv_byte(reply);
        check_byte("write reply", reply, REPLY_ACK);
        model_write(addr, data);
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_word_t data);
        uart_byte_t b;
        data = '0;
        send_byte(OP_READ);
        send_byte(addr);
        for (int i = 0; i < 4; i++) begin
            recv_byte(b);
            data = {data[23:0], b};
        end
    endtask

    function logic probe(int sel);
        if (sel == 0) return pulse_20khz;
        if (sel == 1) return pulse_2khz;
        return power_good;
    endfunction

    // Cycles between two pulses for sel 0 and 1, or two toggles for sel 2
    task automatic measure_gap(input int sel, output int gap);
        logic prev;
        logic cur;
        int   t0;
        int   found;
        prev = probe(sel);
        found = 0;
        gap = 0;
        t0 = 0;
        while (found < 2) begin
            @(negedge sys_clk);
            cur = probe(sel);
            if ((sel < 2) ? cur : (cur != prev)) begin
                if (found == 0) t0 = cycle_cnt;
                else gap = cycle_cnt - t0;
                found++;
            end
            prev = cur;
        end
    endtask

    initial begin
        int         start;
        int         n;
        int         gap;
        reg_addr_t  addr;
        reg_word_t  data;
        uart_byte_t b;
        logic [31:0] r;

        rst = 1'b1;
        uart_rxd = 1'b1;                    // Line idle
        ref_clk_16khz = 1'b0;
        ref_en = 1'b0;
        for (int i = 0; i < 256; i++) model_regs[i] = '0;
        repeat (5) @(posedge sys_clk);      // Five reset cycles
        @(negedge sys_clk);
        rst = 1'b0;

        start = fail_cnt;                   // Chain disabled out of reset
        n = 0;
        repeat (500) begin
            @(negedge sys_clk);
            if (pulse_20khz || pulse_2khz) n++;
        end
        check_count("pulses while disabled", n, 0, 0);
        report_test("quiet", start);

        start = fail_cnt;
        for (int i = 0; i < 20; i++) begin
            r = xorshift32();
            addr = r[0] ? ADDR_SCRATCH1 : ADDR_SCRATCH0;
            write_reg(addr, xorshift32());
            r = xorshift32();
            addr = r[0] ? ADDR_SCRATCH1 : ADDR_SCRATCH0;  // Reads hit either pad
            read_reg(addr, data);
            check_word("scratch read", data, model_read(addr));
        end
        report_test("scratch", start);

        start = fail_cnt;
        write_reg(ADDR_ID, xorshift32());   // Read-only word ignores the write
        read_reg(ADDR_ID, data);
        check_word("id word", data, model_read(ADDR_ID));
        do begin
            r = xorshift32();
            addr = r[7:0];
        end while (is_mapped(addr));
        write_reg(addr, xorshift32());
        read_reg(addr, data);
        check_word("unmapped read", data, model_read(addr));
        report_test("id_unmap", start);

        start = fail_cnt;
        do begin
            r = xorshift32();
            b = r[7:0];
        end while (b == OP_WRITE || b == OP_READ);
        send_byte(b);
        recv_byte(b);
        check_byte("bad opcode reply", b, REPLY_NAK);
        n = 0;
        repeat (30 * BIT_CLKS) begin        // Nothing more may follow the NAK
            @(negedge sys_clk);
            if (uart_txd !== 1'b1) n++;
        end
        check_count("txd low cycles after nak", n, 0, 0);
        read_reg(ADDR_SCRATCH0, data);
        check_word("read after nak", data, model_read(ADDR_SCRATCH0));
        report_test("nak", start);

        start = fail_cnt;
        write_reg(ADDR_CLK_CTRL, 32'h1);
        measure_gap(0, gap);
        check_count("pulse_20khz gap", gap, GAP_20K, 0);
        measure_gap(1, gap);
        check_count("pulse_2khz gap", gap, GAP_2K, 0);
        read_reg(ADDR_CLK_CTRL, data);
        check_word("clk_ctrl", data, model_read(ADDR_CLK_CTRL));
        report_test("pulses", start);

        start = fail_cnt;
        measure_gap(2, gap);
        check_count("power_good half period", gap, GAP_PG, 0);
        report_test("power_good", start);

        start = fail_cnt;
        ref_en = 1'b1;
        repeat (2 * REF_PERIOD) @(negedge sys_clk);  // Let the reference settle
        write_reg(ADDR_OSC_COUNT, xorshift32());     // Any value restarts
        repeat (GATE + 40) @(negedge sys_clk);
        read_reg(ADDR_OSC_COUNT, data);
        check_count("osc_count", int'(data), GATE / REF_PERIOD, 1);
        report_test("osc", start);

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
syscon_pkg.sv
uart_port.sv
cmd_server.sv
reg_decode.sv
pulse_gen.sv
osc_counter.sv
syscon_top.sv
tb_syscon.sv

/* Bender.yml */
package:
  name: syscon

sources:
  - syscon_pkg.sv
  - uart_port.sv
  - cmd_server.sv
  - reg_decode.sv
  - pulse_gen.sv
  - osc_counter.sv
  - syscon_top.sv
  - target: test
    files:
      - tb_syscon.sv
